//--- src/me_pkg.sv
`default_nettype none

package me_pkg;

  typedef logic [7:0]  pixel_t;   // one image sample
  typedef logic [7:0]  raddr_t;   // reference memory address
  typedef logic [9:0]  saddr_t;   // search memory address
  typedef logic [4:0]  coord_t;   // row or column inside the search window
  typedef logic [16:0] sad_val_t; // accumulated sum of absolute differences

  typedef struct packed {
    sad_val_t sad;
    saddr_t   addr; // top-left pixel of the candidate in search memory
  } sad_t;

  // issued by the control once per cycle
  typedef struct packed {
    logic   valid;
    logic   first;   // first pixel of a pass
    logic   last;    // last pixel of a pass
    coord_t pix_row; // pixel inside the reference block
    coord_t pix_col;
    coord_t org_row; // leftmost candidate of the pass
    coord_t org_col;
  } scan_t;

  // travels with the data once the addresses are formed
  typedef struct packed {
    logic   valid;
    logic   first;
    logic   last;
    saddr_t origin; // search address of the pass's first candidate
  } pass_t;

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    DRAIN,
    DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/me_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module me_ctrl import me_pkg::*; #(
  parameter int unsigned RImgSize = 16,
  parameter int unsigned SImgSize = 31,
  parameter int unsigned PeNum    = 8
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  output scan_t scan_o,
  output logic  first_pass_o,
  output logic  busy_o,
  output logic  finish_o
);

  localparam int unsigned NCand     = SImgSize - RImgSize + 1; // candidates per row and column
  localparam int unsigned PipeDepth = 4; // last issue to running-best update
  localparam int unsigned DrainW    = $clog2(PipeDepth);

  localparam coord_t LastPix    = coord_t'(RImgSize - 1);
  localparam coord_t LastOrgCol = coord_t'(NCand - PeNum);
  localparam coord_t LastOrgRow = coord_t'(NCand - 1);

  ctrl_state_e state_q, state_d;

  logic              start_q;
  logic              start_edge;
  coord_t            pix_row_q, pix_col_q;
  coord_t            org_row_q, org_col_q;
  logic [DrainW-1:0] drain_cnt_q;
  logic              first_pass_q;
  logic              pix_first, pix_last;
  logic              final_pix;

  assign start_edge = start_i && !start_q;

  assign pix_first = (pix_row_q == '0) && (pix_col_q == '0);
  assign pix_last  = (pix_row_q == LastPix) && (pix_col_q == LastPix);
  assign final_pix = pix_last && (org_row_q == LastOrgRow) && (org_col_q == LastOrgCol);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (start_edge) state_d = SCAN;
      SCAN:    if (final_pix) state_d = DRAIN;
      DRAIN:   if (drain_cnt_q == DrainW'(PipeDepth - 1)) state_d = DONE;
      DONE:    if (start_edge) state_d = SCAN; // new search, old result held until here
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      start_q      <= 1'b0;
      pix_row_q    <= '0;
      pix_col_q    <= '0;
      org_row_q    <= '0;
      org_col_q    <= '0;
      drain_cnt_q  <= '0;
      first_pass_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= start_i;

      if ((state_q == IDLE || state_q == DONE) && start_edge) begin
        pix_row_q    <= '0;
        pix_col_q    <= '0;
        org_row_q    <= '0;
        org_col_q    <= '0;
        first_pass_q <= 1'b1;
      end else if (state_q == SCAN) begin
        // pixel column first, then row
        if (pix_col_q == LastPix) begin
          pix_col_q <= '0;
          if (pix_row_q == LastPix) pix_row_q <= '0;
          else pix_row_q <= pix_row_q + 1'b1;
        end else begin
          pix_col_q <= pix_col_q + 1'b1;
        end

        if (pix_last) begin
          first_pass_q <= 1'b0;
          if (org_col_q == LastOrgCol) begin // next candidate row
            org_col_q <= '0;
            org_row_q <= org_row_q + 1'b1;
          end else begin
            org_col_q <= org_col_q + coord_t'(PeNum);
          end
        end
      end

      if (state_q == DRAIN) drain_cnt_q <= drain_cnt_q + 1'b1;
      else drain_cnt_q <= '0;
    end
  end

  always_comb begin
    scan_o.valid   = (state_q == SCAN);
    scan_o.first   = scan_o.valid && pix_first;
    scan_o.last    = scan_o.valid && pix_last;
    scan_o.pix_row = pix_row_q;
    scan_o.pix_col = pix_col_q;
    scan_o.org_row = org_row_q;
    scan_o.org_col = org_col_q;
  end

  assign first_pass_o = first_pass_q;
  assign busy_o       = (state_q == SCAN) || (state_q == DRAIN);
  assign finish_o     = (state_q == DONE);

endmodule

`default_nettype wire

//--- src/me_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module me_addr_gen import me_pkg::*; #(
  parameter int unsigned RImgSize = 16,
  parameter int unsigned SImgSize = 31,
  parameter int unsigned PeNum    = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  scan_t                scan_i,
  output raddr_t               ref_raddr_o,
  output saddr_t [PeNum-1:0]   smem_raddr_o,
  output pass_t                pass_o
);

  raddr_t             ref_addr_d;
  saddr_t             row_base;  // start of the search row under the current pixel
  saddr_t             col_base;
  saddr_t             origin_d;
  saddr_t [PeNum-1:0] smem_addr_d;

  always_comb begin
    ref_addr_d = raddr_t'(scan_i.pix_row * RImgSize) + raddr_t'(scan_i.pix_col);

    row_base = saddr_t'((scan_i.org_row + scan_i.pix_row) * SImgSize);
    col_base = saddr_t'(scan_i.org_col) + saddr_t'(scan_i.pix_col);

    // PE k looks at the candidate k columns right of the pass origin
    for (int k = 0; k < PeNum; k++) begin
      smem_addr_d[k] = row_base + col_base + saddr_t'(k);
    end

    origin_d = saddr_t'(scan_i.org_row * SImgSize) + saddr_t'(scan_i.org_col);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pass_o.valid <= 1'b0;
      pass_o.first <= 1'b0;
      pass_o.last  <= 1'b0;
    end else begin
      pass_o.valid <= scan_i.valid;
      pass_o.first <= scan_i.first;
      pass_o.last  <= scan_i.last;
    end
    ref_raddr_o   <= ref_addr_d;
    smem_raddr_o  <= smem_addr_d;
    pass_o.origin <= origin_d;
  end

endmodule

`default_nettype wire

//--- src/me_pe_array.sv
`timescale 1ns/100ps
`default_nettype none

module me_pe_array import me_pkg::*; #(
  parameter int unsigned PeNum = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  pass_t                pass_i,
  input  pixel_t               ref_data_i,
  input  pixel_t   [PeNum-1:0] smem_data_i,
  output sad_val_t [PeNum-1:0] sads_o,
  output pass_t                pass_o
);

  pass_t                pass_q; // lines up with the memory data
  sad_val_t [PeNum-1:0] accum_q;

  function automatic pixel_t abs_diff(pixel_t a, pixel_t b);
    return (a > b) ? a - b : b - a;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pass_q.valid <= 1'b0;
      pass_q.first <= 1'b0;
      pass_q.last  <= 1'b0;
      pass_o.valid <= 1'b0;
      pass_o.first <= 1'b0;
      pass_o.last  <= 1'b0;
    end else begin
      pass_q.valid <= pass_i.valid;
      pass_q.first <= pass_i.first;
      pass_q.last  <= pass_i.last;
      pass_o.valid <= pass_q.valid && pass_q.last; // sums complete
      pass_o.first <= 1'b0;
      pass_o.last  <= pass_q.valid && pass_q.last;
    end
    pass_q.origin <= pass_i.origin;
    pass_o.origin <= pass_q.origin;
  end

  always_ff @(posedge clk_i) begin
    if (pass_q.valid) begin
      for (int k = 0; k < PeNum; k++) begin
        if (pass_q.first) begin // start of a new pass
          accum_q[k] <= sad_val_t'(abs_diff(ref_data_i, smem_data_i[k]));
        end else begin
          accum_q[k] <= accum_q[k] + sad_val_t'(abs_diff(ref_data_i, smem_data_i[k]));
        end
      end
    end
  end

  assign sads_o = accum_q;

endmodule

`default_nettype wire

//--- src/me_min_select.sv
`timescale 1ns/100ps
`default_nettype none

module me_min_select import me_pkg::*; #(
  parameter int unsigned PeNum = 8 // power of two for the pairwise tree
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  sad_val_t [PeNum-1:0] sads_i,
  input  pass_t                pass_i,
  input  logic                 first_pass_i,
  output sad_t                 min_sad_o
);

  // first_pass_i is sampled with the last pixel issue, pass_i is valid three cycles later
  localparam int unsigned FpDelay = 3;

  sad_t               node [2*PeNum-1]; // heap order, leaves at the end
  logic [FpDelay-1:0] first_pass_q;
  logic               load;

  always_comb begin
    for (int k = 0; k < PeNum; k++) begin
      node[PeNum-1+k].sad  = sads_i[k];
      node[PeNum-1+k].addr = pass_i.origin + saddr_t'(k);
    end

    // left child has the lower index and keeps ties
    for (int n = PeNum - 2; n >= 0; n--) begin
      if (node[2*n+2].sad < node[2*n+1].sad) begin
        node[n] = node[2*n+2];
      end else begin
        node[n] = node[2*n+1];
      end
    end
  end

  // earlier passes are earlier in raster order so only a strictly smaller SAD replaces
  assign load = pass_i.valid && pass_i.last &&
                (first_pass_q[FpDelay-1] || (node[0].sad < min_sad_o.sad));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      first_pass_q <= '0;
      min_sad_o    <= '0;
    end else begin
      first_pass_q <= {first_pass_q[FpDelay-2:0], first_pass_i};
      if (load) min_sad_o <= node[0];
    end
  end

endmodule

`default_nettype wire

//--- src/me_engine.sv
`timescale 1ns/100ps
`default_nettype none

module me_engine import me_pkg::*; #(
  parameter int unsigned RImgSize = 16,
  parameter int unsigned SImgSize = 31,
  parameter int unsigned PeNum    = 8  // (SImgSize - RImgSize + 1) must be a multiple
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  pixel_t             ref_data_i,
  input  pixel_t [PeNum-1:0] smem_data_i,
  output raddr_t             ref_raddr_o,
  output saddr_t [PeNum-1:0] smem_raddr_o,
  output logic               busy_o,
  output logic               finish_o,
  output sad_t               min_sad_o
);

  scan_t                scan;
  pass_t                addr_pass;
  pass_t                pe_pass;
  sad_val_t [PeNum-1:0] sads;
  logic                 first_pass;

  me_ctrl #(
    .RImgSize (RImgSize),
    .SImgSize (SImgSize),
    .PeNum    (PeNum)
  ) i_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .scan_o       (scan),
    .first_pass_o (first_pass),
    .busy_o       (busy_o),
    .finish_o     (finish_o)
  );

  me_addr_gen #(
    .RImgSize (RImgSize),
    .SImgSize (SImgSize),
    .PeNum    (PeNum)
  ) i_addr_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .scan_i       (scan),
    .ref_raddr_o  (ref_raddr_o),
    .smem_raddr_o (smem_raddr_o),
    .pass_o       (addr_pass)
  );

  me_pe_array #(
    .PeNum (PeNum)
  ) i_pe_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pass_i      (addr_pass),
    .ref_data_i  (ref_data_i),
    .smem_data_i (smem_data_i),
    .sads_o      (sads),
    .pass_o      (pe_pass)
  );

  me_min_select #(
    .PeNum (PeNum)
  ) i_min_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sads_i       (sads),
    .pass_i       (pe_pass),
    .first_pass_i (first_pass),
    .min_sad_o    (min_sad_o)
  );

endmodule

`default_nettype wire

//--- bench/me_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module me_mem_model import me_pkg::*; #(
  parameter int unsigned RImgSize = 16,
  parameter int unsigned SImgSize = 31,
  parameter int unsigned PeNum    = 8
) (
  input  logic               clk_i,
  input  raddr_t             ref_raddr_i,
  input  saddr_t [PeNum-1:0] smem_raddr_i,
  output pixel_t             ref_data_o,
  output pixel_t [PeNum-1:0] smem_data_o
);

  localparam int unsigned RefPix  = RImgSize * RImgSize;
  localparam int unsigned SrchPix = SImgSize * SImgSize;

  // both images are written by the testbench between searches
  pixel_t ref_mem  [RefPix];
  pixel_t srch_mem [SrchPix];

  always_ff @(posedge clk_i) begin
    ref_data_o <= ref_mem[ref_raddr_i]; // data one cycle after the address
    for (int k = 0; k < PeNum; k++) begin
      smem_data_o[k] <= srch_mem[smem_raddr_i[k]];
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_me_engine.sv
`timescale 1ns/100ps
`default_nettype none

module tb_me_engine import me_pkg::*; ();

  localparam int unsigned RImgSize = 16;
  localparam int unsigned SImgSize = 31;
  localparam int unsigned PeNum    = 8;
  localparam int unsigned NCand    = SImgSize - RImgSize + 1;
  localparam int unsigned RefPix   = RImgSize * RImgSize;
  localparam int unsigned SrchPix  = SImgSize * SImgSize;
  // every pass over every block pixel, the margin covers drain and start
  localparam int unsigned SearchCycles  = (NCand * NCand / PeNum) * RefPix;
  localparam int unsigned NumSearches   = 6;
  localparam int unsigned TimeoutCycles = NumSearches * (SearchCycles + 1800);

  logic               clk_i;
  logic               rst_ni;
  logic               start_i;
  pixel_t             ref_data;
  pixel_t [PeNum-1:0] smem_data;
  raddr_t             ref_raddr;
  saddr_t [PeNum-1:0] smem_raddr;
  logic               busy;
  logic               finish;
  sad_t               min_sad;

  pixel_t      ref_img  [RefPix];
  pixel_t      srch_img [SrchPix];
  int unsigned cycle_cnt = 0;

  me_engine #(
    .RImgSize (RImgSize),
    .SImgSize (SImgSize),
    .PeNum    (PeNum)
  ) me_engine_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .ref_data_i   (ref_data),
    .smem_data_i  (smem_data),
    .ref_raddr_o  (ref_raddr),
    .smem_raddr_o (smem_raddr),
    .busy_o       (busy),
    .finish_o     (finish),
    .min_sad_o    (min_sad)
  );

  me_mem_model #(
    .RImgSize (RImgSize),
    .SImgSize (SImgSize),
    .PeNum    (PeNum)
  ) mem_i (
    .clk_i        (clk_i),
    .ref_raddr_i  (ref_raddr),
    .smem_raddr_i (smem_raddr),
    .ref_data_o   (ref_data),
    .smem_data_o  (smem_data)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: no end of the tests after %0d cycles", TimeoutCycles);
      $display("Regression failed");
      $fatal(1);
    end
  end

  task automatic fail_with_message(input string msg);
    $display("%0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_sad(input string name, input sad_t expected, input sad_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected sad=%0d addr=%0d actual sad=%0d addr=%0d",
               $time, name, expected.sad, expected.addr, actual.sad, actual.addr);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic fill_pattern();
    for (int a = 0; a < RefPix; a++) begin
      ref_img[a] = pixel_t'(a);
    end
    for (int a = 0; a < SrchPix; a++) begin
      srch_img[a] = pixel_t'(a ^ (a >> 2)); // every address bit shows up
    end
  endtask

  task automatic fill_random();
    for (int a = 0; a < RefPix; a++) begin
      ref_img[a] = pixel_t'($urandom);
    end
    for (int a = 0; a < SrchPix; a++) begin
      srch_img[a] = pixel_t'($urandom);
    end
  endtask

  task automatic fill_const(input pixel_t ref_val, input pixel_t srch_val);
    for (int a = 0; a < RefPix; a++) begin
      ref_img[a] = ref_val;
    end
    for (int a = 0; a < SrchPix; a++) begin
      srch_img[a] = srch_val;
    end
  endtask

  task automatic load_images();
    for (int a = 0; a < RefPix; a++) begin
      mem_i.ref_mem[a] = ref_img[a];
    end
    for (int a = 0; a < SrchPix; a++) begin
      mem_i.srch_mem[a] = srch_img[a];
    end
  endtask

  // brute force over all candidates where the first in raster order keeps a tie
  task automatic compute_expected(output sad_t best);
    int sad;
    int diff;
    best = '0;
    for (int r = 0; r < NCand; r++) begin
      for (int c = 0; c < NCand; c++) begin
        sad = 0;
        for (int y = 0; y < RImgSize; y++) begin
          for (int x = 0; x < RImgSize; x++) begin
            diff = int'(ref_img[y * RImgSize + x]) - int'(srch_img[(r + y) * SImgSize + c + x]);
            sad += (diff < 0) ? -diff : diff;
          end
        end
        if ((r == 0 && c == 0) || sad < int'(best.sad)) begin
          best.sad  = sad_val_t'(sad);
          best.addr = saddr_t'(r * SImgSize + c);
        end
      end
    end
  endtask

  task automatic run_search(input logic hold_start);
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    if (!hold_start) start_i <= 1'b0;
    @(negedge clk_i);
    check_level("finish_o", 1'b0, finish);
    while (!finish) begin
      check_level("busy_o", 1'b1, busy);
      @(negedge clk_i);
    end
    check_level("busy_o", 1'b0, busy);
  endtask

  task automatic search_and_check(input logic hold_start);
    sad_t expected;
    compute_expected(expected);
    load_images();
    run_search(hold_start);
    check_sad("min_sad_o", expected, min_sad);
  endtask

  task automatic test_reset_start();
    @(negedge clk_i);
    check_level("busy_o", 1'b0, busy);
    check_level("finish_o", 1'b0, finish);
    check_sad("min_sad_o", '0, min_sad);
    fill_random();
    search_and_check(1'b0);
  endtask

  task automatic test_random();
    fill_random();
    search_and_check(1'b0);
  endtask

  task automatic test_planted();
    fill_random();
    for (int y = 0; y < RImgSize; y++) begin
      for (int x = 0; x < RImgSize; x++) begin
        srch_img[(9 + y) * SImgSize + 13 + x] = ref_img[y * RImgSize + x];
      end
    end
    load_images();
    run_search(1'b0);
    check_sad("min_sad_o", {17'd0, 10'(9 * SImgSize + 13)}, min_sad);
  endtask

  task automatic test_ties();
    fill_const(8'h40, 8'h40);
    load_images();
    run_search(1'b0);
    check_sad("min_sad_o", {17'd0, 10'd0}, min_sad);
    fill_const(8'h45, 8'h40); // every candidate at 5 per pixel
    load_images();
    run_search(1'b0);
    check_sad("min_sad_o", {17'd1280, 10'd0}, min_sad);
  endtask

  task automatic test_back_to_back();
    sad_t prev;
    sad_t expected;
    prev = min_sad;
    fill_random();
    compute_expected(expected);
    if (expected.sad <= prev.sad) begin
      fail_with_message("back-to-back images do not give a larger SAD than the previous search");
    end
    load_images();
    run_search(1'b1);
    check_sad("min_sad_o", expected, min_sad);
    // start_i still high so there is no new rising edge
    repeat (16) begin
      @(negedge clk_i);
      check_level("busy_o", 1'b0, busy);
      check_level("finish_o", 1'b1, finish);
    end
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'hbd74));
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    fill_pattern();
    load_images();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset_start();
    test_random();
    test_planted();
    test_ties();
    test_back_to_back();

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- me_engine.f
src/me_pkg.sv
src/me_ctrl.sv
src/me_addr_gen.sv
src/me_pe_array.sv
src/me_min_select.sv
src/me_engine.sv
bench/me_mem_model.sv
bench/tb_me_engine.sv

//--- Bender.yml
package:
  name: me_engine

sources:
  - src/me_pkg.sv
  - src/me_ctrl.sv
  - src/me_addr_gen.sv
  - src/me_pe_array.sv
  - src/me_min_select.sv
  - src/me_engine.sv
  - target: test
    files:
      - bench/me_mem_model.sv
      - bench/tb_me_engine.sv
